/* mesh_pkg.sv */
package mesh_pkg;

    // **********************************************************
    // grid geometry
    // **********************************************************

    localparam int MESH_DIM = 4;    // tiles per side, also lane count

    // **********************************************************
    // data widths and element types
    // **********************************************************

    localparam int A_W   = 8;       // left-edge operand
    localparam int ACC_W = 20;      // partial sums and weights share this width

    // one a operand, signed
    typedef logic signed [A_W-1:0] a_t;

    // partial sum or weight word, signed, wraps on overflow
    typedef logic signed [ACC_W-1:0] acc_t;

    // **********************************************************
    // fixed latency
    // **********************************************************

    // edge that samples a beat to the edge that presents its result
    // skew in, one stage per tile row, deskew and output register
    localparam int MESH_LATENCY = 2 * MESH_DIM;

endpackage

/* tag_pkg.sv */
package tag_pkg;

    // beat tags ride alongside the data but never enter the grid

    localparam int ID_W = 3;

    // id of a beat, returned with its result
    typedef logic [ID_W-1:0] id_t;

    // payload of the tag delay line
    typedef struct packed {
        id_t  id;
        logic last;     // marks the final beat of a sequence
    } tag_t;

endpackage

/* delay_line.sv */
`timescale 1ns/1ps

module delay_line #(
    parameter int  DEPTH     = 1,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t din,
    output payload_t dout
);

    generate
        if (DEPTH == 0) begin : g_bypass
            assign dout = din;  // zero-length lane
        end else begin : g_chain
            payload_t stage_q [DEPTH];

            always_ff @(posedge clk) begin
                if (rst) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stage_q[i] <= '0;
                    end
                end else begin
                    stage_q[0] <= din;
                    for (int i = 1; i < DEPTH; i++) begin
                        stage_q[i] <= stage_q[i-1];
                    end
                end
            end

            assign dout = stage_q[DEPTH-1];
        end
    endgenerate

endmodule

/* operand_skew.sv */
`timescale 1ns/1ps

module operand_skew (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  logic                          in_propagate,
    input  mesh_pkg::a_t                  in_a [mesh_pkg::MESH_DIM],
    input  mesh_pkg::acc_t                in_b [mesh_pkg::MESH_DIM],
    input  mesh_pkg::acc_t                in_d [mesh_pkg::MESH_DIM],
    output mesh_pkg::a_t                  row_a [mesh_pkg::MESH_DIM],
    output mesh_pkg::acc_t                col_b [mesh_pkg::MESH_DIM],
    output mesh_pkg::acc_t                col_d [mesh_pkg::MESH_DIM],
    output logic [mesh_pkg::MESH_DIM-1:0] col_valid,
    output logic [mesh_pkg::MESH_DIM-1:0] col_propagate
);

    import mesh_pkg::*;

    logic beat_valid;
    logic beat_propagate;
    a_t   beat_a [MESH_DIM];
    acc_t beat_b [MESH_DIM];
    acc_t beat_d [MESH_DIM];

    // **********************************************************
    // input register
    // **********************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_valid     <= 1'b0;
            beat_propagate <= 1'b0;
        end else begin
            beat_valid     <= in_valid;
            beat_propagate <= in_propagate;
        end
    end

    // bubbles enter as zeros so they add nothing down a column
    always_ff @(posedge clk) begin
        for (int k = 0; k < MESH_DIM; k++) begin
            beat_a[k] <= in_valid ? in_a[k] : '0;
            beat_b[k] <= in_valid ? in_b[k] : '0;
            beat_d[k] <= in_valid ? in_d[k] : '0;
        end
    end

    // **********************************************************
    // stagger, lane k waits k cycles
    // **********************************************************

    for (genvar k = 0; k < MESH_DIM; k++) begin : g_lane
        logic [1:0] ctrl_dly;   // valid, propagate

        delay_line #(.DEPTH(k), .payload_t(a_t)) u_a_dly (
            .clk  (clk),
            .rst  (rst),
            .din  (beat_a[k]),
            .dout (row_a[k])
        );

        delay_line #(.DEPTH(k), .payload_t(acc_t)) u_b_dly (
            .clk  (clk),
            .rst  (rst),
            .din  (beat_b[k]),
            .dout (col_b[k])
        );

        delay_line #(.DEPTH(k), .payload_t(acc_t)) u_d_dly (
            .clk  (clk),
            .rst  (rst),
            .din  (beat_d[k]),
            .dout (col_d[k])
        );

        delay_line #(.DEPTH(k), .payload_t(logic [1:0])) u_ctrl_dly (
            .clk  (clk),
            .rst  (rst),
            .din  ({beat_valid, beat_propagate}),
            .dout (ctrl_dly)
        );

        assign col_valid[k]     = ctrl_dly[1];
        assign col_propagate[k] = ctrl_dly[0];
    end

endmodule

/* pe_tile.sv */
`timescale 1ns/1ps

module pe_tile (
    input  logic           clk,
    input  logic           rst,
    input  mesh_pkg::a_t   a_in,
    output mesh_pkg::a_t   a_out,
    input  mesh_pkg::acc_t psum_in,
    output mesh_pkg::acc_t psum_out,
    input  mesh_pkg::acc_t shadow_in,
    output mesh_pkg::acc_t shadow_out,
    input  logic           valid_in,
    output logic           valid_out,
    input  logic           propagate_in,
    output logic           propagate_out
);

    import mesh_pkg::*;

    acc_t shadow_q;     // weight being preloaded
    acc_t active_q;     // weight the products use
    logic prop_q;       // propagate bit of the last valid beat
    logic flip;
    acc_t weight;
    acc_t a_ext;

    // a changed propagate bit swaps the banks ahead of this beat's product
    assign flip   = valid_in && (propagate_in != prop_q);
    assign weight = flip ? shadow_q : active_q;
    assign a_ext  = acc_t'(a_in);   // sign extend

    // **********************************************************
    // weight banks
    // **********************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            shadow_q <= '0;
            active_q <= '0;
            prop_q   <= 1'b0;
        end else if (valid_in) begin
            shadow_q <= shadow_in;
            if (flip) begin
                active_q <= shadow_q;   // old shadow, not the one arriving now
                prop_q   <= propagate_in;
            end
        end
    end

    // **********************************************************
    // systolic outputs
    // **********************************************************

    // the displaced shadow moves one row down per valid beat,
    // so row r ends up holding the weight from r beats earlier
    always_ff @(posedge clk) begin
        if (rst) begin
            shadow_out    <= '0;
            valid_out     <= 1'b0;
            propagate_out <= 1'b0;
        end else begin
            shadow_out    <= shadow_q;
            valid_out     <= valid_in;
            propagate_out <= propagate_in;
        end
    end

    always_ff @(posedge clk) begin
        a_out    <= a_in;
        psum_out <= psum_in + a_ext * weight;   // wraps at ACC_W
    end

endmodule

/* result_deskew.sv */
`timescale 1ns/1ps

module result_deskew (
    input  logic                          clk,
    input  logic                          rst,
    input  mesh_pkg::acc_t                col_c [mesh_pkg::MESH_DIM],
    input  logic [mesh_pkg::MESH_DIM-1:0] col_valid,
    input  tag_pkg::tag_t                 tag,
    output logic                          out_valid,
    output mesh_pkg::acc_t                out_c [mesh_pkg::MESH_DIM],
    output tag_pkg::id_t                  out_id,
    output logic                          out_last
);

    import mesh_pkg::*;
    import tag_pkg::*;

    acc_t lane_c [MESH_DIM];    // columns realigned
    logic lane_valid;
    tag_t tag_q;

    // **********************************************************
    // undo the stagger, column j waits MESH_DIM-1-j cycles
    // **********************************************************

    for (genvar j = 0; j < MESH_DIM; j++) begin : g_col
        delay_line #(.DEPTH(MESH_DIM - 1 - j), .payload_t(acc_t)) u_c_dly (
            .clk  (clk),
            .rst  (rst),
            .din  (col_c[j]),
            .dout (lane_c[j])
        );
    end

    // column 0 is the slowest lane, its valid marks the aligned beat
    delay_line #(.DEPTH(MESH_DIM - 1), .payload_t(logic)) u_valid_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (col_valid[0]),
        .dout (lane_valid)
    );

    // tag arrives one stage ahead of column 0
    always_ff @(posedge clk) begin
        tag_q <= tag;
    end

    // **********************************************************
    // output register, holds between valid beats
    // **********************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_id    <= '0;
            out_last  <= 1'b0;
            for (int k = 0; k < MESH_DIM; k++) begin
                out_c[k] <= '0;
            end
        end else begin
            out_valid <= lane_valid;
            if (lane_valid) begin
                out_id   <= tag_q.id;
                out_last <= tag_q.last;
                for (int k = 0; k < MESH_DIM; k++) begin
                    out_c[k] <= lane_c[k];
                end
            end
        end
    end

endmodule

/* mesh_top.sv */
`timescale 1ns/1ps

module mesh_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  logic           in_propagate,
    input  tag_pkg::id_t   in_id,
    input  logic           in_last,
    input  mesh_pkg::a_t   in_a [mesh_pkg::MESH_DIM],
    input  mesh_pkg::acc_t in_b [mesh_pkg::MESH_DIM],
    input  mesh_pkg::acc_t in_d [mesh_pkg::MESH_DIM],
    output logic           out_valid,
    output mesh_pkg::acc_t out_c [mesh_pkg::MESH_DIM],
    output tag_pkg::id_t   out_id,
    output logic           out_last
);

    import mesh_pkg::*;
    import tag_pkg::*;

    // **********************************************************
    // grid wiring
    // **********************************************************

    a_t                  a_bus      [MESH_DIM+1][MESH_DIM];   // [col][row]
    acc_t                psum_bus   [MESH_DIM+1][MESH_DIM];   // [row][col]
    acc_t                shadow_bus [MESH_DIM+1][MESH_DIM];   // [row][col]
    logic [MESH_DIM-1:0] valid_bus  [MESH_DIM+1];             // [row], bit per col
    logic [MESH_DIM-1:0] prop_bus   [MESH_DIM+1];
    tag_t                tag_dly;

    operand_skew u_operand_skew (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_propagate  (in_propagate),
        .in_a          (in_a),
        .in_b          (in_b),
        .in_d          (in_d),
        .row_a         (a_bus[0]),
        .col_b         (psum_bus[0]),
        .col_d         (shadow_bus[0]),
        .col_valid     (valid_bus[0]),
        .col_propagate (prop_bus[0])
    );

    // **********************************************************
    // tile array, a moves right, everything else moves down
    // **********************************************************

    for (genvar r = 0; r < MESH_DIM; r++) begin : g_row
        for (genvar c = 0; c < MESH_DIM; c++) begin : g_col
            pe_tile u_pe_tile (
                .clk           (clk),
                .rst           (rst),
                .a_in          (a_bus[c][r]),
                .a_out         (a_bus[c+1][r]),
                .psum_in       (psum_bus[r][c]),
                .psum_out      (psum_bus[r+1][c]),
                .shadow_in     (shadow_bus[r][c]),
                .shadow_out    (shadow_bus[r+1][c]),
                .valid_in      (valid_bus[r][c]),
                .valid_out     (valid_bus[r+1][c]),
                .propagate_in  (prop_bus[r][c]),
                .propagate_out (prop_bus[r+1][c])
            );
        end
    end

    // id and last bypass the grid
    delay_line #(.DEPTH(MESH_LATENCY - 1), .payload_t(tag_t)) u_tag_dly (
        .clk  (clk),
        .rst  (rst),
        .din  ({in_id, in_last}),
        .dout (tag_dly)
    );

    result_deskew u_result_deskew (
        .clk       (clk),
        .rst       (rst),
        .col_c     (psum_bus[MESH_DIM]),
        .col_valid (valid_bus[MESH_DIM]),
        .tag       (tag_dly),
        .out_valid (out_valid),
        .out_c     (out_c),
        .out_id    (out_id),
        .out_last  (out_last)
    );

endmodule

/* tb_mesh_top.sv */
`timescale 1ns/1ps

module tb_mesh_top;

    import mesh_pkg::*;
    import tag_pkg::*;

    // **********************************************************
    // trace layout, one row of 23 hex words per cycle
    // **********************************************************

    localparam int N_LINES     = 26;
    localparam int FIELDS      = 23;
    localparam int F_VALID     = 0;
    localparam int F_PROP      = 1;
    localparam int F_ID        = 2;
    localparam int F_LAST      = 3;
    localparam int F_A         = 4;     // a0..a3
    localparam int F_B         = 8;     // b0..b3
    localparam int F_D         = 12;    // d0..d3
    localparam int F_EXP_VALID = 16;
    localparam int F_EXP_ID    = 17;
    localparam int F_EXP_LAST  = 18;
    localparam int F_EXP_C     = 19;    // c0..c3

    localparam int RUN_STEPS      = N_LINES + MESH_LATENCY + 1;
    localparam int TIMEOUT_CYCLES = N_LINES + 20;

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic             in_propagate;
    id_t              in_id;
    logic             in_last;
    a_t               in_a [MESH_DIM];
    acc_t             in_b [MESH_DIM];
    acc_t             in_d [MESH_DIM];
    logic             out_valid;
    acc_t             out_c [MESH_DIM];
    id_t              out_id;
    logic             out_last;

    logic [ACC_W-1:0] trace_mem [N_LINES*FIELDS];
    int               error_count;
    int               check_count;
    int               cycle_count;

    mesh_top u_mesh_top (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_propagate (in_propagate),
        .in_id        (in_id),
        .in_last      (in_last),
        .in_a         (in_a),
        .in_b         (in_b),
        .in_d         (in_d),
        .out_valid    (out_valid),
        .out_c        (out_c),
        .out_id       (out_id),
        .out_last     (out_last)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [ACC_W-1:0] trace_field(int line, int col);
        return trace_mem[line * FIELDS + col];
    endfunction

    task automatic drive_idle();
        in_valid     <= 1'b0;
        in_propagate <= 1'b0;
        in_id        <= '0;
        in_last      <= 1'b0;
        for (int k = 0; k < MESH_DIM; k++) begin
            in_a[k] <= '0;
            in_b[k] <= '0;
            in_d[k] <= '0;
        end
    endtask

    task automatic drive_line(int line);
        logic [ACC_W-1:0] word;
        word = trace_field(line, F_VALID);
        in_valid <= word[0];
        word = trace_field(line, F_PROP);
        in_propagate <= word[0];
        word = trace_field(line, F_ID);
        in_id <= word[ID_W-1:0];
        word = trace_field(line, F_LAST);
        in_last <= word[0];
        for (int k = 0; k < MESH_DIM; k++) begin
            word = trace_field(line, F_A + k);
            in_a[k] <= word[A_W-1:0];   // only the low byte is the operand
            in_b[k] <= trace_field(line, F_B + k);
            in_d[k] <= trace_field(line, F_D + k);
        end
    endtask

    // nothing has reached the output yet
    task automatic check_idle_outputs();
        assert (out_valid == 1'b0) else begin
            error_count++;
            $display("Fail at %0t: out_valid expected 0, got %b", $time, out_valid);
        end
        for (int k = 0; k < MESH_DIM; k++) begin
            assert (out_c[k] == '0) else begin
                error_count++;
                $display("Fail at %0t: out_c[%0d] expected 00000, got %h", $time, k, out_c[k]);
            end
        end
    endtask

    task automatic check_line(int line);
        logic [ACC_W-1:0] word;
        logic             exp_valid;
        id_t              exp_id;
        logic             exp_last;
        acc_t             exp_c;
        word = trace_field(line, F_EXP_VALID);
        exp_valid = word[0];
        word = trace_field(line, F_EXP_ID);
        exp_id = word[ID_W-1:0];
        word = trace_field(line, F_EXP_LAST);
        exp_last = word[0];
        check_count++;
        assert (out_valid == exp_valid) else begin
            error_count++;
            $display("Fail at %0t: out_valid expected %b, got %b (line %0d)",
                     $time, exp_valid, out_valid, line);
        end
        assert (out_id == exp_id) else begin
            error_count++;
            $display("Fail at %0t: out_id expected %0d, got %0d (line %0d)",
                     $time, exp_id, out_id, line);
        end
        assert (out_last == exp_last) else begin
            error_count++;
            $display("Fail at %0t: out_last expected %b, got %b (line %0d)",
                     $time, exp_last, out_last, line);
        end
        for (int k = 0; k < MESH_DIM; k++) begin
            exp_c = trace_field(line, F_EXP_C + k);
            assert (out_c[k] == exp_c) else begin
                error_count++;
                $display("Fail at %0t: out_c[%0d] expected %h, got %h (line %0d)",
                         $time, k, exp_c, out_c[k], line);
            end
        end
    endtask

    // **********************************************************
    // stimulus and checking
    // **********************************************************

    initial begin : stimulus
        error_count = 0;
        check_count = 0;
        rst <= 1'b1;
        drive_idle();
        $readmemh("mesh_trace.txt", trace_mem);
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // line m is sampled one edge after it is driven, its result lands 8 edges later
        for (int step = 0; step < RUN_STEPS; step++) begin
            @(posedge clk);
            if (step < N_LINES) begin
                drive_line(step);
            end else begin
                drive_idle();
            end
            @(negedge clk);     // outputs settled mid cycle
            if (step > MESH_LATENCY) begin
                check_line(step - MESH_LATENCY - 1);
            end else begin
                check_idle_outputs();
            end
        end

        $display("%0d trace lines checked, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

/* mesh_trace.txt */
// valid prop id last  a0 a1 a2 a3  b0 b1 b2 b3  d0 d1 d2 d3  (inputs, hex)
// exp_valid exp_id exp_last  c0 c1 c2 c3  (result seen 8 cycles after the beat)
0 0 0 0  0 0 0 0     0 0 0 0              0 0 0 0              0 0 0  0 0 0 0
0 0 0 0  0 0 0 0     0 0 0 0              0 0 0 0              0 0 0  0 0 0 0
1 0 0 0  0 0 0 0     11 22 33 44          2 1 ffffd 7          1 0 0  11 22 33 44
1 0 1 0  0 0 0 0     fffff 0 1 2          3 ffffe 1 0          1 1 0  fffff 0 1 2
1 0 2 0  0 0 0 0     0 0 0 0              fffff 0 5 2          1 2 0  0 0 0 0
1 0 3 1  0 0 0 0     80000 7ffff 1 fffff  1 2 3 4              1 3 1  80000 7ffff 1 fffff
1 1 4 0  1 2 3 4     64 c8 12c 190        0 0 0 0              1 4 0  74 c8 130 1b4
1 1 5 0  ff 5 fe 3   0 0 0 0              0 0 0 0              1 5 0  ffffa 5 b 1b
1 1 6 0  a 0 0 f6    1 2 3 4              0 0 0 0              1 6 0  ffff7 c 3f fffe6
0 0 0 0  0 0 0 0     0 0 0 0              0 0 0 0              0 6 0  ffff7 c 3f fffe6
0 0 0 0  0 0 0 0     0 0 0 0              0 0 0 0              0 6 0  ffff7 c 3f fffe6
1 1 7 1  7f 80 1 0   0 0 0 0              0 0 0 0              1 7 1  102 fc ffefe fc
1 1 0 0  2 2 2 2     0 0 0 0              3 9c40 1 c0000       1 0 0  a 2 c 1a
1 1 1 0  0 0 0 1     3e8 0 0 0            4e20 0 ffff9 2       1 1 0  3ea 1 ffffd 7
0 0 0 0  0 0 0 0     0 0 0 0              0 0 0 0              0 1 0  3ea 1 ffffd 7
1 1 2 0  fd 0 0 0    0 0 0 0              ffe0c 12c 4 1        1 2 0  ffffd ffffa ffff7 ffff4
1 1 3 0  0 1 ff 0    5 5 5 5              7ffff fffff 2 0      1 3 0  1 7 9 7
1 0 4 0  7f 80 1 ff  0 0 0 0              0 0 0 0              1 4 0  9479e ecd41 ffef6 3ff82
1 0 5 0  80 80 80 80 1 0 0 0              0 0 0 0              1 5 0  9e901 14a80 0 ffe80
1 0 6 1  1 1 1 1     10 0 0 1             0 0 0 0              1 6 1  84c3e 9d6b 0 c0004
0 0 0 0  0 0 0 0     0 0 0 0              0 0 0 0              0 6 1  84c3e 9d6b 0 c0004
0 0 0 0  0 0 0 0     0 0 0 0              0 0 0 0              0 6 1  84c3e 9d6b 0 c0004
0 0 0 0  0 0 0 0     0 0 0 0              0 0 0 0              0 6 1  84c3e 9d6b 0 c0004
0 0 0 0  0 0 0 0     0 0 0 0              0 0 0 0              0 6 1  84c3e 9d6b 0 c0004
0 0 0 0  0 0 0 0     0 0 0 0              0 0 0 0              0 6 1  84c3e 9d6b 0 c0004
0 0 0 0  0 0 0 0     0 0 0 0              0 0 0 0              0 6 1  84c3e 9d6b 0 c0004

/* ws_mesh.f */
mesh_pkg.sv
tag_pkg.sv
delay_line.sv
operand_skew.sv
pe_tile.sv
result_deskew.sv
mesh_top.sv
tb_mesh_top.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module tb_mesh_top -f ws_mesh.f
./obj_dir/Vtb_mesh_top > sim.log 2>&1
cat sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
